// File: Makefile
# Verilator build and run of the timer subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_timer_subsystem
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing
# Let the run continue past assertion errors so the testbench can report them
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
rtl/obi_timer_pkg.sv
rtl/obi_timer.sv
rtl/obi_timer_demux.sv
rtl/timer_subsystem.sv
verification/tb_clock_gen.sv
verification/timer_subsystem_checker.sv
verification/tb_timer_subsystem.sv

// File: rtl/obi_timer.sv
/*
  One 32-bit timer behind an OBI target with gnt tied high.
  The response is registered and follows the request by one cycle.
  Register writes win over counting in the same cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module obi_timer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  obi_timer_pkg::obi_req_t obi_req_i,
  output obi_timer_pkg::obi_rsp_t obi_rsp_o,
  output logic                    expired_o,
  output logic                    overflow_o
);

  // Timer state
  logic [31:0] count_d, count_q;
  logic [31:0] compare_d, compare_q;
  logic        enable_d, enable_q;
  logic        autoreset_d, autoreset_q;
  logic        expired_d, expired_q;
  logic        overflow_d, overflow_q;

  // Response pipeline
  logic                   rvalid_q;
  logic [31:0]            rdata_d, rdata_q;
  obi_timer_pkg::obi_id_t rid_q;

  logic [31:0]                             be_mask;
  logic [obi_timer_pkg::TimerAddrBits-1:0] reg_off;
  logic                                    expired_event;
  logic                                    overflow_event;

  // Expand byte enables into a bit mask
  for (genvar i = 0; i < 4; i++) begin : gen_be_mask
    assign be_mask[8*i +: 8] = {8{obi_req_i.a.be[i]}};
  end

  // Word aligned offset, bits 1:0 ignored
  assign reg_off = {obi_req_i.a.addr[obi_timer_pkg::TimerAddrBits-1:2], 2'b00};

  assign expired_event  = enable_q && (compare_q != 32'h0) && (count_q >= compare_q);
  assign overflow_event = enable_q && (count_q == 32'hFFFF_FFFF);

  assign expired_o  = expired_q;
  assign overflow_o = overflow_q;

  // Every offset in the window is decoded, so err stays low
  always_comb begin
    obi_rsp_o         = '0;
    obi_rsp_o.gnt     = 1'b1;
    obi_rsp_o.rvalid  = rvalid_q;
    obi_rsp_o.r.rdata = rdata_q;
    obi_rsp_o.r.rid   = rid_q;
  end

  always_comb begin
    count_d     = count_q;
    compare_d   = compare_q;
    enable_d    = enable_q;
    autoreset_d = autoreset_q;
    expired_d   = expired_q;
    overflow_d  = overflow_q;
    rdata_d     = '0;

    // Counting, autoreset takes the expired condition back to zero
    if (autoreset_q && expired_event) begin
      count_d = '0;
    end else if (enable_q) begin
      count_d = count_q + 32'd1;
    end

    if (expired_event) begin
      expired_d = 1'b1;
    end
    if (overflow_event) begin
      overflow_d = 1'b1;
    end

    // Bus access, overrides the counting above
    if (obi_req_i.req) begin
      if (obi_req_i.a.we) begin
        case (reg_off)
          obi_timer_pkg::CountOffset: begin
            count_d = (count_q & ~be_mask) | (obi_req_i.a.wdata & be_mask);
          end
          obi_timer_pkg::CompareOffset: begin
            compare_d = (compare_q & ~be_mask) | (obi_req_i.a.wdata & be_mask);
            count_d   = '0;
          end
          obi_timer_pkg::CtrlOffset: begin
            if (be_mask[obi_timer_pkg::CtrlEnableBit]) begin
              enable_d = obi_req_i.a.wdata[obi_timer_pkg::CtrlEnableBit];
            end
            if (be_mask[obi_timer_pkg::CtrlAutoresetBit]) begin
              autoreset_d = obi_req_i.a.wdata[obi_timer_pkg::CtrlAutoresetBit];
            end
          end
          obi_timer_pkg::StatusOffset: begin
            // Write 1 to clear
            if (be_mask[obi_timer_pkg::StatusExpiredBit] &&
                obi_req_i.a.wdata[obi_timer_pkg::StatusExpiredBit]) begin
              expired_d = 1'b0;
            end
            if (be_mask[obi_timer_pkg::StatusOverflowBit] &&
                obi_req_i.a.wdata[obi_timer_pkg::StatusOverflowBit]) begin
              overflow_d = 1'b0;
            end
          end
          default: begin
          end
        endcase
      end else begin
        case (reg_off)
          obi_timer_pkg::CountOffset: begin
            rdata_d = count_q;
          end
          obi_timer_pkg::CompareOffset: begin
            rdata_d = compare_q;
          end
          obi_timer_pkg::CtrlOffset: begin
            rdata_d[obi_timer_pkg::CtrlEnableBit]    = enable_q;
            rdata_d[obi_timer_pkg::CtrlAutoresetBit] = autoreset_q;
          end
          obi_timer_pkg::StatusOffset: begin
            rdata_d[obi_timer_pkg::StatusExpiredBit]  = expired_q;
            rdata_d[obi_timer_pkg::StatusOverflowBit] = overflow_q;
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q     <= '0;
      compare_q   <= '0;
      enable_q    <= 1'b0;
      autoreset_q <= 1'b0;
      expired_q   <= 1'b0;
      overflow_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      count_q     <= count_d;
      compare_q   <= compare_d;
      enable_q    <= enable_d;
      autoreset_q <= autoreset_d;
      expired_q   <= expired_d;
      overflow_q  <= overflow_d;
      rvalid_q    <= obi_req_i.req;
    end
  end

  // Response payload, only meaningful while rvalid is high
  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
    rid_q   <= obi_req_i.a.aid;
  end

endmodule

`default_nettype wire

// File: rtl/obi_timer_demux.sv
/*
  Routes OBI requests to NumTimers timer windows, 1 to 16 of them.
  Requests go through combinationally and responses are picked one cycle
  later. Indices at or above NumTimers get an error response from here.
*/
`timescale 1ns/1ps
`default_nettype none

module obi_timer_demux #(
  parameter int unsigned NumTimers = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  obi_timer_pkg::obi_req_t obi_req_i,
  output obi_timer_pkg::obi_rsp_t obi_rsp_o,
  output obi_timer_pkg::obi_req_t timer_req_o [NumTimers],
  input  obi_timer_pkg::obi_rsp_t timer_rsp_i [NumTimers]
);

  localparam int unsigned IdxBits = obi_timer_pkg::TimerIdxBits;
  // Width of an index into the timer bank
  localparam int unsigned SelBits = (NumTimers > 1) ? $clog2(NumTimers) : 1;

  logic [IdxBits-1:0]     sel_idx;
  logic                   in_range;
  logic [SelBits-1:0]     sel_q;
  logic                   err_vld_q;
  logic                   we_q;
  obi_timer_pkg::obi_id_t aid_q;

  // Timer index sits just above the register window
  assign sel_idx  = obi_req_i.a.addr[obi_timer_pkg::TimerAddrBits +: IdxBits];
  assign in_range = 32'(sel_idx) < NumTimers;

  // Address and data go to every timer, req only to the selected one
  for (genvar i = 0; i < NumTimers; i++) begin : gen_req
    always_comb begin
      timer_req_o[i]     = obi_req_i;
      timer_req_o[i].req = obi_req_i.req && in_range && (32'(sel_idx) == i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q     <= '0;
      err_vld_q <= 1'b0;
    end else begin
      err_vld_q <= obi_req_i.req && !in_range;
      // Keep the last valid index so the response mux never points past the bank
      if (obi_req_i.req && in_range) begin
        sel_q <= sel_idx[SelBits-1:0];
      end
    end
  end

  // Needed only for the locally built error response
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      we_q  <= obi_req_i.a.we;
      aid_q <= obi_req_i.a.aid;
    end
  end

  always_comb begin
    if (err_vld_q) begin
      obi_rsp_o          = '0;
      obi_rsp_o.rvalid   = 1'b1;
      obi_rsp_o.r.err    = 1'b1;
      obi_rsp_o.r.rid    = aid_q;
      obi_rsp_o.r.rdata  = we_q ? 32'h0 : obi_timer_pkg::ErrorRdata;
    end else begin
      obi_rsp_o = timer_rsp_i[sel_q];
    end
    // No back-pressure anywhere in the block
    obi_rsp_o.gnt = 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/obi_timer_pkg.sv
/*
  Shared OBI types and the timer address map. Only aid, rid and err are
  carried from the optional OBI signal set. Each timer owns a 16-byte window
  and up to 16 windows are decoded above it.
*/
`default_nettype none

package obi_timer_pkg;

  // Transaction id shared by request and response
  typedef logic [3:0] obi_id_t;

  // Request address channel
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
    obi_id_t     aid;
  } obi_a_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  // Response channel
  typedef struct packed {
    logic [31:0] rdata;
    obi_id_t     rid;
    logic        err;
  } obi_r_chan_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

  // Low address bits that select a register inside one timer window
  localparam int unsigned TimerAddrBits = 4;

  // Address bits above the window that select the timer
  localparam int unsigned TimerIdxBits = 4;

  // Register byte offsets inside a window
  localparam logic [TimerAddrBits-1:0] CountOffset   = 4'h0;
  localparam logic [TimerAddrBits-1:0] CompareOffset = 4'h4;
  localparam logic [TimerAddrBits-1:0] CtrlOffset    = 4'h8;
  localparam logic [TimerAddrBits-1:0] StatusOffset  = 4'hC;

  // Read data returned with err set
  localparam logic [31:0] ErrorRdata = 32'hBADCAB1E;

  // CTRL fields
  localparam int unsigned CtrlEnableBit    = 0;
  localparam int unsigned CtrlAutoresetBit = 1;

  // STATUS fields, write 1 to clear
  localparam int unsigned StatusExpiredBit  = 0;
  localparam int unsigned StatusOverflowBit = 1;

endpackage

`default_nettype wire

// File: rtl/timer_subsystem.sv
/*
  Bank of NumTimers OBI timers behind one target port, 1 to 16 timers.
  Timer i answers at byte offset i*16; flags are level outputs per timer.
*/
`timescale 1ns/1ps
`default_nettype none

module timer_subsystem #(
  parameter int unsigned NumTimers = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  obi_timer_pkg::obi_req_t obi_req_i,
  output obi_timer_pkg::obi_rsp_t obi_rsp_o,
  output logic [NumTimers-1:0]    expired_o,
  output logic [NumTimers-1:0]    overflow_o
);

  obi_timer_pkg::obi_req_t timer_req [NumTimers];
  obi_timer_pkg::obi_rsp_t timer_rsp [NumTimers];

  obi_timer_demux #(
    .NumTimers (NumTimers)
  ) u_demux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .obi_req_i   (obi_req_i),
    .obi_rsp_o   (obi_rsp_o),
    .timer_req_o (timer_req),
    .timer_rsp_i (timer_rsp)
  );

  // One timer per window
  for (genvar i = 0; i < NumTimers; i++) begin : gen_timer
    obi_timer u_timer (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .obi_req_i  (timer_req[i]),
      .obi_rsp_o  (timer_rsp[i]),
      .expired_o  (expired_o[i]),
      .overflow_o (overflow_o[i])
    );
  end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/*
  Free-running testbench clock and an active-low reset.
  Reset is released on a falling edge after ResetCycles rising edges.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PeriodNs    = 8,
  parameter int ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_timer_subsystem.sv
/*
  Directed tests for timer_subsystem with four timers. Inputs change on the
  falling edge and responses are sampled mid-cycle, one cycle after the request.
  Assertion failures of the bound checker count as errors too.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_timer_subsystem;

  localparam int NumTimers   = 4;
  localparam int ClkPeriodNs = 8;
  localparam int RspTimeout  = 4;
  // Cycles per test at two cycles per bus access, then reset and a margin
  localparam int TestCycles   = 48 + 36 + 90 + 90 + 40 + 6 + 5;
  localparam int MarginCycles = 200;
  // Byte-enable patterns for the COUNT merge test, one nibble each
  localparam logic [31:0] BePatterns = 32'hC3A5_8421;

  logic                    clk;
  logic                    rst_n;
  obi_timer_pkg::obi_req_t obi_req;
  obi_timer_pkg::obi_rsp_t obi_rsp;
  logic [NumTimers-1:0]    expired;
  logic [NumTimers-1:0]    overflow;

  logic [31:0] rng_state;
  logic [31:0] timer1_count;
  int unsigned errors;

  tb_clock_gen #(
    .PeriodNs    (ClkPeriodNs),
    .ResetCycles (4)
  ) u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  timer_subsystem #(
    .NumTimers (NumTimers)
  ) uut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .obi_req_i  (obi_req),
    .obi_rsp_o  (obi_rsp),
    .expired_o  (expired),
    .overflow_o (overflow)
  );

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s, expected 0x%08h, got 0x%08h",
               $time, what, expected, actual);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  function automatic logic [31:0] reg_addr(input int idx, input logic [3:0] off);
    return (32'(idx) << obi_timer_pkg::TimerAddrBits) | 32'(off);
  endfunction

  // One OBI access with a random aid, checks rid, err and write rdata
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, input logic exp_err,
                            output logic [31:0] rdata);
    logic [31:0] rnd;
    int          waited;
    rnd    = xorshift32();
    waited = 0;
    @(negedge clk);
    obi_req.req     = 1'b1;
    obi_req.a.addr  = addr;
    obi_req.a.we    = we;
    obi_req.a.be    = be;
    obi_req.a.wdata = wdata;
    obi_req.a.aid   = rnd[3:0];
    @(negedge clk);
    obi_req.req = 1'b0;
    while (!obi_rsp.rvalid && waited < RspTimeout) begin
      @(negedge clk);
      waited++;
    end
    rdata = obi_rsp.r.rdata;
    if (!obi_rsp.rvalid) begin
      errors++;
      $display("Error at %0t ns: no response to the access at 0x%08h", $time, addr);
    end else begin
      check_value(32'(rnd[3:0]), 32'(obi_rsp.r.rid), "rid against aid");
      check_value(32'(exp_err), 32'(obi_rsp.r.err), "err flag");
      if (we) begin
        check_value(32'h0, obi_rsp.r.rdata, "rdata of a write");
      end
    end
  endtask

  task automatic reg_write(input int idx, input logic [3:0] off, input logic [31:0] data);
    logic [31:0] unused_rdata;
    bus_access(1'b1, reg_addr(idx, off), 4'hF, data, 1'b0, unused_rdata);
  endtask

  task automatic reg_read(input int idx, input logic [3:0] off, output logic [31:0] data);
    bus_access(1'b0, reg_addr(idx, off), 4'hF, 32'h0, 1'b0, data);
  endtask

  task automatic test_register_readback();
    logic [31:0] cmp;
    logic [31:0] ctrl;
    logic [31:0] rd;
    for (int t = 0; t < NumTimers; t++) begin
      // Earlier writes must not have reached this timer
      reg_read(t, obi_timer_pkg::CompareOffset, rd);
      check_value(32'h0, rd, "COMPARE of a timer not yet written");
      reg_read(t, obi_timer_pkg::CtrlOffset, rd);
      check_value(32'h0, rd, "CTRL of a timer not yet written");
      cmp  = xorshift32();
      ctrl = xorshift32() & ~(32'h1 << obi_timer_pkg::CtrlEnableBit);
      reg_write(t, obi_timer_pkg::CompareOffset, cmp);
      reg_write(t, obi_timer_pkg::CtrlOffset, ctrl);
      reg_read(t, obi_timer_pkg::CompareOffset, rd);
      check_value(cmp, rd, "COMPARE read-back");
      reg_read(t, obi_timer_pkg::CtrlOffset, rd);
      check_value(ctrl & 32'h3, rd, "CTRL read-back");
    end
  endtask

  task automatic test_byte_enables();
    logic [31:0] expected;
    logic [31:0] wdata;
    logic [31:0] rd;
    logic [31:0] unused_rdata;
    logic [3:0]  be;
    reg_write(1, obi_timer_pkg::CtrlOffset, 32'h0);
    expected = 32'h1122_3344;
    reg_write(1, obi_timer_pkg::CountOffset, expected);
    for (int i = 0; i < 8; i++) begin
      be    = BePatterns[4*i +: 4];
      wdata = xorshift32();
      bus_access(1'b1, reg_addr(1, obi_timer_pkg::CountOffset), be, wdata, 1'b0,
                 unused_rdata);
      expected = merge_bytes(expected, wdata, be);
      reg_read(1, obi_timer_pkg::CountOffset, rd);
      check_value(expected, rd, $sformatf("COUNT after a write with be 0x%h", be));
    end
    timer1_count = expected;
  endtask

  task automatic test_expiry();
    logic [31:0] rd;
    int          polls;
    reg_write(2, obi_timer_pkg::CompareOffset, 32'd10);
    reg_write(2, obi_timer_pkg::CtrlOffset, 32'h1 << obi_timer_pkg::CtrlEnableBit);
    polls = 0;
    rd    = '0;
    while (!rd[obi_timer_pkg::StatusExpiredBit] && polls < 40) begin
      reg_read(2, obi_timer_pkg::StatusOffset, rd);
      polls++;
    end
    check_value(32'h1, 32'(rd[obi_timer_pkg::StatusExpiredBit]), "STATUS expired of timer 2");
    check_value(32'h4, 32'(expired), "expired_o with only timer 2 expired");
    // Disable first, otherwise the flag sets again on the next edge
    reg_write(2, obi_timer_pkg::CtrlOffset, 32'h0);
    reg_write(2, obi_timer_pkg::StatusOffset, 32'h1 << obi_timer_pkg::StatusExpiredBit);
    reg_read(2, obi_timer_pkg::StatusOffset, rd);
    check_value(32'h0, rd, "STATUS of timer 2 after clear");
    check_value(32'h0, 32'(expired), "expired_o after clear");
  endtask

  task automatic test_autoreset();
    logic [31:0] rd;
    reg_write(3, obi_timer_pkg::CompareOffset, 32'd20);
    reg_write(3, obi_timer_pkg::CtrlOffset, 32'h3);
    // 40 reads at two cycles each span 80 cycles
    for (int i = 0; i < 40; i++) begin
      reg_read(3, obi_timer_pkg::CountOffset, rd);
      check_value(32'h1, 32'(rd <= 32'd20), $sformatf("COUNT 0x%08h at most COMPARE", rd));
    end
    reg_read(3, obi_timer_pkg::StatusOffset, rd);
    check_value(32'h1, 32'(rd[obi_timer_pkg::StatusExpiredBit]), "STATUS expired of timer 3");
    check_value(32'h1, 32'(expired[3]), "expired_o of timer 3");
    reg_write(3, obi_timer_pkg::CtrlOffset, 32'h0);
    reg_write(3, obi_timer_pkg::StatusOffset, 32'h3);
  endtask

  task automatic test_overflow();
    logic [31:0] rd;
    reg_write(0, obi_timer_pkg::CompareOffset, 32'h0);
    reg_write(0, obi_timer_pkg::CountOffset, 32'hFFFF_FFF0);
    reg_write(0, obi_timer_pkg::CtrlOffset, 32'h1 << obi_timer_pkg::CtrlEnableBit);
    repeat (24) @(negedge clk);
    check_value(32'h1, 32'(overflow), "overflow_o with only timer 0 overflowed");
    reg_read(0, obi_timer_pkg::StatusOffset, rd);
    check_value(32'h1 << obi_timer_pkg::StatusOverflowBit, rd, "STATUS after overflow");
    reg_read(0, obi_timer_pkg::CountOffset, rd);
    check_value(32'h1, 32'(rd < 32'd64), $sformatf("COUNT 0x%08h wrapped to small value", rd));
    reg_write(0, obi_timer_pkg::CtrlOffset, 32'h0);
    reg_write(0, obi_timer_pkg::StatusOffset, 32'h3);
  endtask

  task automatic test_unmapped();
    logic [31:0] rd;
    logic [31:0] addr;
    logic [31:0] unused_rdata;
    int          idx;
    rd  = xorshift32();
    // Index 5, 9 or 13 lands on timer 1 if the upper index bits were dropped
    idx = 5 + 4 * int'(rd % 32'd3);
    // Bits above the timer index are ignored, so they get random values
    addr = {rd[31:8], 4'(idx), obi_timer_pkg::CountOffset};
    bus_access(1'b0, addr, 4'hF, 32'h0, 1'b1, rd);
    check_value(obi_timer_pkg::ErrorRdata, rd, "rdata of an unmapped read");
    bus_access(1'b1, addr, 4'hF, xorshift32(), 1'b1, unused_rdata);
    reg_read(1, obi_timer_pkg::CountOffset, rd);
    check_value(timer1_count, rd, "timer 1 COUNT after unmapped accesses");
  endtask

  initial begin
    #((TestCycles + MarginCycles) * ClkPeriodNs);
    $display("Timeout: tests did not complete within %0d cycles", TestCycles + MarginCycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    obi_req      = '0;
    rng_state    = 32'd12719;
    timer1_count = '0;
    errors       = 0;
    wait (rst_n === 1'b1);
    test_register_readback();
    test_byte_enables();
    test_expiry();
    test_autoreset();
    test_overflow();
    test_unmapped();
    repeat (2) @(negedge clk);
    $display("Closing: %0d check errors, %0d assertion failures",
             errors, uut.u_checker.assert_fails);
    if (errors == 0 && uut.u_checker.assert_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/timer_subsystem_checker.sv
/*
  OBI handshake assertions for timer_subsystem, attached with bind.
  Checks are disabled while reset is asserted. assert_fails counts
  failures so that the testbench can fold them into its result.
*/
`timescale 1ns/1ps
`default_nettype none

module timer_subsystem_checker (
  input logic                    clk_i,
  input logic                    rst_ni,
  input obi_timer_pkg::obi_req_t obi_req_i,
  input obi_timer_pkg::obi_rsp_t obi_rsp_i
);

  int unsigned assert_fails = 0;

  // No back-pressure, gnt stays high
  gnt_high: assert property (@(posedge clk_i) disable iff (!rst_ni) obi_rsp_i.gnt)
    else begin
      assert_fails++;
      $error("gnt low while out of reset");
    end

  // Exactly one response, one cycle after each accepted request
  rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      obi_rsp_i.rvalid == $past(obi_req_i.req))
    else begin
      assert_fails++;
      $error("rvalid does not follow the accepted request by one cycle");
    end

  rid_matches_aid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      obi_rsp_i.rvalid |-> obi_rsp_i.r.rid == $past(obi_req_i.a.aid))
    else begin
      assert_fails++;
      $error("rid differs from the aid of the previous cycle");
    end

endmodule

bind timer_subsystem timer_subsystem_checker u_checker (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .obi_req_i (obi_req_i),
  .obi_rsp_i (obi_rsp_o)
);

`default_nettype wire
